// ==== Makefile ====
TOOL       = verilator
TOP        = tb_img_ctrl
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/img_apb_regs.sv ====
`timescale 1ns/1ps

module img_apb_regs (
    input  logic                                               clk,
    input  logic                                               fifoIn_rst,
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               pwrite,
    input  logic [img_pkg::APB_AW-1:0]                         paddr,
    input  logic [img_pkg::APB_DW-1:0]                         pwdata,
    output logic [img_pkg::APB_DW-1:0]                         prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    input  logic                                               cap_busy,
    input  logic                                               rd_busy,
    input  logic                                               cap_overflow,
    input  logic [img_pkg::STAT_W-1:0]                         highlight_count,
    input  logic [img_pkg::STAT_W-1:0]                         shadow_count,
    input  logic [img_pkg::NUM_BANKS-1:0][img_pkg::CNT_W-1:0]  bank_count,
    output logic                                               cap_start,
    output logic                                               rd_start,
    output logic [img_pkg::BSEL_W-1:0]                         bank_sel,
    output logic [img_pkg::HDR_W-1:0]                          header
);
    import img_pkg::*;

    logic access;
    logic addr_ok;
    logic start_req;
    logic start_bad;
    logic wr_ok;
    logic cap_busy_q;
    logic rd_busy_q;
    logic cap_done;
    logic rd_done;

    // Zero wait states so each transfer completes in the access phase
    assign pready = 1'b1;
    assign access = psel && penable;

    // ==================================================
    // Address decode and readback
    // ==================================================
    always_comb begin
        addr_ok = 1'b1;
        prdata  = '0;
        case (paddr)
            REG_CTRL:       prdata[CTRL_BANK_BIT +: BSEL_W] = bank_sel;
            REG_STATUS:     prdata[4:0] = {cap_overflow, rd_done, rd_busy, cap_done, cap_busy};
            REG_HDR_LO:     prdata = header[APB_DW-1:0];
            REG_HDR_HI:     prdata = header[HDR_W-1:APB_DW];
            REG_WORD_COUNT: prdata[CNT_W-1:0] = bank_count[bank_sel];
            REG_HIGHLIGHT:  prdata[STAT_W-1:0] = highlight_count;
            REG_SHADOW:     prdata[STAT_W-1:0] = shadow_count;
            default:        addr_ok = 1'b0;
        endcase
    end

    // Start while busy, or both starts at once, is refused
    assign start_req = pwrite && (paddr == REG_CTRL)
                       && (pwdata[CTRL_CAP_BIT] || pwdata[CTRL_RD_BIT]);
    assign start_bad = start_req && (cap_busy || rd_busy
                       || (pwdata[CTRL_CAP_BIT] && pwdata[CTRL_RD_BIT]));
    assign pslverr   = access && (!addr_ok || start_bad);
    assign wr_ok     = access && pwrite && addr_ok && !start_bad;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            cap_start  <= 1'b0;
            rd_start   <= 1'b0;
            bank_sel   <= '0;
            header     <= '0;
            cap_busy_q <= 1'b0;
            rd_busy_q  <= 1'b0;
            cap_done   <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            cap_start <= wr_ok && (paddr == REG_CTRL) && pwdata[CTRL_CAP_BIT];
            rd_start  <= wr_ok && (paddr == REG_CTRL) && pwdata[CTRL_RD_BIT];
            if (wr_ok) begin
                case (paddr)
                    REG_CTRL:   bank_sel <= pwdata[CTRL_BANK_BIT +: BSEL_W];
                    REG_HDR_LO: header[APB_DW-1:0] <= pwdata;
                    REG_HDR_HI: header[HDR_W-1:APB_DW] <= pwdata;
                    default: ;
                endcase
            end

            // Done flags latch on the falling edge of busy
            cap_busy_q <= cap_busy;
            rd_busy_q  <= rd_busy;
            if (cap_start) begin
                cap_done <= 1'b0;
            end else if (cap_busy_q && !cap_busy) begin
                cap_done <= 1'b1;
            end
            if (rd_start) begin
                rd_done <= 1'b0;
            end else if (rd_busy_q && !rd_busy) begin
                rd_done <= 1'b1;
            end
        end
    end

    // A start pulse never finds either engine busy
    a_start_idle: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (cap_start || rd_start) |-> !(cap_busy || rd_busy));

endmodule

// ==== rtl/img_capture.sv ====
`timescale 1ns/1ps

module img_capture (
    input  logic                               clk,
    input  logic                               fifoIn_rst,
    input  logic                               cap_start,
    input  logic [img_pkg::BSEL_W-1:0]         bank_sel,
    input  logic [img_pkg::HDR_W-1:0]          header,
    input  logic                               img_fv,
    input  logic                               img_lv,
    input  logic [img_pkg::PIX_W-1:0]          img_d,
    input  logic [img_pkg::NUM_BANKS-1:0]      bank_full,
    output logic [img_pkg::NUM_BANKS-1:0]      bank_wr_en,
    output logic [img_pkg::NUM_BANKS-1:0]      bank_clear,
    output logic [img_pkg::WORD_W-1:0]         bank_wr_data,
    output logic                               cap_busy,
    output logic                               cap_overflow,
    output logic [img_pkg::STAT_W-1:0]         highlight_count,
    output logic [img_pkg::STAT_W-1:0]         shadow_count
);
    import img_pkg::*;

    cap_state_t                   state;
    logic [BSEL_W-1:0]            sel_q;
    logic [HDR_W-1:0]             hdr_sh;
    logic [$clog2(HDR_WORDS)-1:0] hdr_cnt;
    logic                         wr_req;
    logic                         lv_q;
    logic [1:0]                   col;
    logic [1:0]                   line;
    logic                         stat_en;
    logic [PIX_W-1:0]             stat_px;

    assign cap_busy = (state != CAP_IDLE);

    // Writes into a full bank are dropped here
    always_comb begin
        bank_wr_en        = '0;
        bank_wr_en[sel_q] = wr_req && !bank_full[sel_q];
    end

    // ==================================================
    // Frame FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state        <= CAP_IDLE;
            sel_q        <= '0;
            bank_clear   <= '0;
            wr_req       <= 1'b0;
            hdr_cnt      <= '0;
            cap_overflow <= 1'b0;
        end else begin
            bank_clear <= '0;
            wr_req     <= 1'b0;
            if (wr_req && bank_full[sel_q]) begin
                cap_overflow <= 1'b1;
            end
            case (state)
                CAP_IDLE: begin
                    if (cap_start) begin
                        sel_q                <= bank_sel;
                        bank_clear[bank_sel] <= 1'b1;
                        cap_overflow         <= 1'b0;
                        state                <= CAP_WAIT_FV_LOW;
                    end
                end
                // A frame in progress is skipped
                CAP_WAIT_FV_LOW: begin
                    if (!img_fv) state <= CAP_WAIT_FV_HIGH;
                end
                CAP_WAIT_FV_HIGH: begin
                    hdr_cnt <= '0;
                    if (img_fv) state <= CAP_HEADER;
                end
                CAP_HEADER: begin
                    wr_req  <= 1'b1;
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == HDR_WORDS - 1) state <= CAP_PIXELS;
                end
                CAP_PIXELS: begin
                    wr_req <= img_fv && img_lv;
                    if (!img_fv) state <= CAP_IDLE;
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Header shifts out MSB word first and pixels trail the pins by one stage
    always_ff @(posedge clk) begin
        if (state == CAP_WAIT_FV_HIGH) begin
            hdr_sh <= header;
        end else if (state == CAP_HEADER) begin
            hdr_sh <= hdr_sh << WORD_W;
        end
        if (state == CAP_HEADER) begin
            bank_wr_data <= hdr_sh[HDR_W-1 -: WORD_W];
        end else begin
            bank_wr_data <= WORD_W'(img_d);
        end
        stat_px <= img_d;
    end

    // ==================================================
    // Highlight and shadow statistics
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            lv_q            <= 1'b0;
            col             <= '0;
            line            <= '0;
            stat_en         <= 1'b0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            lv_q <= img_lv;
            col  <= img_lv ? col + 2'd1 : 2'd0;
            if (!img_fv) begin
                line <= '0;
            end else if (lv_q && !img_lv) begin
                line <= line + 2'd1;
            end
            // One pixel in four on every fourth line
            stat_en <= (state == CAP_PIXELS) && img_lv && (col == 2'd0) && (line == 2'd0);

            if (state == CAP_IDLE && cap_start) begin
                highlight_count <= '0;
                shadow_count    <= '0;
            end else if (stat_en) begin
                if (&stat_px[PIX_W-1 -: TONE_BITS]) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (~|stat_px[PIX_W-1 -: TONE_BITS]) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end
        end
    end

    // Every header word lands in exactly one cleared bank
    a_hdr_write: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (state == CAP_HEADER) |=> $onehot(bank_wr_en));

endmodule

// ==== rtl/img_ctrl_top.sv ====
`timescale 1ns/1ps

module img_ctrl_top (
    input  logic                          clk,
    input  logic                          fifoIn_rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [img_pkg::APB_AW-1:0]    paddr,
    input  logic [img_pkg::APB_DW-1:0]    pwdata,
    output logic [img_pkg::APB_DW-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          img_fv,
    input  logic                          img_lv,
    input  logic [img_pkg::PIX_W-1:0]     img_d,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [img_pkg::WORD_W-1:0]    out_data
);
    import img_pkg::*;

    logic                               cap_start;
    logic                               rd_start;
    logic [BSEL_W-1:0]                  bank_sel;
    logic [HDR_W-1:0]                   header;
    logic                               cap_busy;
    logic                               cap_overflow;
    logic                               rd_busy;
    logic [STAT_W-1:0]                  highlight_count;
    logic [STAT_W-1:0]                  shadow_count;
    logic [NUM_BANKS-1:0]               bank_wr_en;
    logic [NUM_BANKS-1:0]               bank_clear;
    logic [WORD_W-1:0]                  bank_wr_data;
    logic [NUM_BANKS-1:0]               bank_full;
    logic [NUM_BANKS-1:0]               bank_avail;
    logic [NUM_BANKS-1:0][WORD_W-1:0]   bank_rd_data;
    logic [NUM_BANKS-1:0][CNT_W-1:0]    bank_count;
    logic [NUM_BANKS-1:0]               bank_rd_en;
    logic [NUM_BANKS-1:0]               bank_rewind;

    img_apb_regs u_img_apb_regs (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .cap_busy        (cap_busy),
        .rd_busy         (rd_busy),
        .cap_overflow    (cap_overflow),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .bank_count      (bank_count),
        .cap_start       (cap_start),
        .rd_start        (rd_start),
        .bank_sel        (bank_sel),
        .header          (header)
    );

    img_capture u_img_capture (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .cap_start       (cap_start),
        .bank_sel        (bank_sel),
        .header          (header),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .img_d           (img_d),
        .bank_full       (bank_full),
        .bank_wr_en      (bank_wr_en),
        .bank_clear      (bank_clear),
        .bank_wr_data    (bank_wr_data),
        .cap_busy        (cap_busy),
        .cap_overflow    (cap_overflow),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    // ==================================================
    // Frame banks
    // ==================================================
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        img_frame_bank u_img_frame_bank (
            .clk        (clk),
            .fifoIn_rst (fifoIn_rst),
            .clear      (bank_clear[i]),
            .wr_en      (bank_wr_en[i]),
            .wr_data    (bank_wr_data),
            .rewind     (bank_rewind[i]),
            .rd_en      (bank_rd_en[i]),
            .full       (bank_full[i]),
            .avail      (bank_avail[i]),
            .rd_data    (bank_rd_data[i]),
            .count      (bank_count[i])
        );
    end

    img_readout u_img_readout (
        .clk          (clk),
        .fifoIn_rst   (fifoIn_rst),
        .rd_start     (rd_start),
        .bank_sel     (bank_sel),
        .bank_avail   (bank_avail),
        .bank_rd_data (bank_rd_data),
        .out_ready    (out_ready),
        .bank_rewind  (bank_rewind),
        .bank_rd_en   (bank_rd_en),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .rd_busy      (rd_busy)
    );

endmodule

// ==== rtl/img_frame_bank.sv ====
`timescale 1ns/1ps

module img_frame_bank (
    input  logic                          clk,
    input  logic                          fifoIn_rst,
    input  logic                          clear,
    input  logic                          wr_en,
    input  logic [img_pkg::WORD_W-1:0]    wr_data,
    input  logic                          rewind,
    input  logic                          rd_en,
    output logic                          full,
    output logic                          avail,
    output logic [img_pkg::WORD_W-1:0]    rd_data,
    output logic [img_pkg::CNT_W-1:0]     count
);
    import img_pkg::*;

    logic [WORD_W-1:0] mem [BANK_DEPTH];
    logic [CNT_W-1:0]  rd_ptr;

    // Write pointer is also the stored frame length
    assign full    = (count == CNT_W'(BANK_DEPTH));
    assign avail   = (rd_ptr < count);
    assign rd_data = mem[rd_ptr[BANK_AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[count[BANK_AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            count  <= '0;
            rd_ptr <= '0;
        end else begin
            if (clear) begin
                count <= '0;
            end else if (wr_en && !full) begin
                count <= count + 1'b1;
            end
            if (clear || rewind) begin
                rd_ptr <= '0;
            end else if (rd_en && avail) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_wr_full: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        wr_en |-> !full);
    a_no_rd_empty: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        rd_en |-> avail);

endmodule

// ==== rtl/img_pkg.sv ====
package img_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int NUM_BANKS  = 2;
    localparam int BANK_DEPTH = 64;
    localparam int BANK_AW    = 6;
    // One extra bit so a full bank can report its depth
    localparam int CNT_W      = BANK_AW + 1;
    localparam int BSEL_W     = $clog2(NUM_BANKS);
    localparam int HDR_WORDS  = 4;
    localparam int PIX_W      = 12;
    localparam int WORD_W     = 16;
    localparam int HDR_W      = HDR_WORDS * WORD_W;
    localparam int STAT_W     = 16;
    // Top pixel bits looked at for highlight and shadow
    localparam int TONE_BITS  = 7;

    // ==================================================
    // APB register map
    // ==================================================
    localparam int APB_AW = 5;
    localparam int APB_DW = 32;

    localparam int CTRL_CAP_BIT  = 0;
    localparam int CTRL_RD_BIT   = 1;
    localparam int CTRL_BANK_BIT = 2;

    typedef enum logic [APB_AW-1:0] {
        REG_CTRL       = 5'h00,
        REG_STATUS     = 5'h04,
        REG_HDR_LO     = 5'h08,
        REG_HDR_HI     = 5'h0C,
        REG_WORD_COUNT = 5'h10,
        REG_HIGHLIGHT  = 5'h14,
        REG_SHADOW     = 5'h18
    } reg_addr_t;

    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_WAIT_FV_LOW,
        CAP_WAIT_FV_HIGH,
        CAP_HEADER,
        CAP_PIXELS
    } cap_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REWIND,
        RD_STREAM
    } rd_state_t;

endpackage

// ==== rtl/img_readout.sv ====
`timescale 1ns/1ps

module img_readout (
    input  logic                                                clk,
    input  logic                                                fifoIn_rst,
    input  logic                                                rd_start,
    input  logic [img_pkg::BSEL_W-1:0]                          bank_sel,
    input  logic [img_pkg::NUM_BANKS-1:0]                       bank_avail,
    input  logic [img_pkg::NUM_BANKS-1:0][img_pkg::WORD_W-1:0]  bank_rd_data,
    input  logic                                                out_ready,
    output logic [img_pkg::NUM_BANKS-1:0]                       bank_rewind,
    output logic [img_pkg::NUM_BANKS-1:0]                       bank_rd_en,
    output logic                                                out_valid,
    output logic [img_pkg::WORD_W-1:0]                          out_data,
    output logic                                                rd_busy
);
    import img_pkg::*;

    rd_state_t         state;
    logic [BSEL_W-1:0] sel_q;
    logic              pop;

    assign rd_busy   = (state != RD_IDLE);
    assign out_valid = (state == RD_STREAM) && bank_avail[sel_q];
    assign out_data  = bank_rd_data[sel_q];
    assign pop       = out_valid && out_ready;

    // Only the latched bank sees rewind and pops
    always_comb begin
        bank_rewind        = '0;
        bank_rd_en         = '0;
        bank_rewind[sel_q] = (state == RD_REWIND);
        bank_rd_en[sel_q]  = pop;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= RD_IDLE;
            sel_q <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_start) begin
                        sel_q <= bank_sel;
                        state <= RD_REWIND;
                    end
                end
                RD_REWIND: state <= RD_STREAM;
                // Done once the stored length has been sent
                RD_STREAM: begin
                    if (!bank_avail[sel_q]) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    a_hold_data: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== testbench/tb_img_ctrl.sv ====
`timescale 1ns/1ps

module tb_img_ctrl;
    import img_pkg::*;

    localparam int MAX_PIX = 128;
    localparam int TIMEOUT = 4000;

    logic              clk;
    logic              fifoIn_rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              img_fv;
    logic              img_lv;
    logic [PIX_W-1:0]  img_d;
    logic              out_valid;
    logic              out_ready;
    logic [WORD_W-1:0] out_data;

    int                seed;
    // Reference copy of the frame last captured into each bank
    logic [PIX_W-1:0]  frame_pix [NUM_BANKS][MAX_PIX];
    logic [HDR_W-1:0]  frame_hdr [NUM_BANKS];
    int                frame_len [NUM_BANKS];

    img_ctrl_top u_img_ctrl_top (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .img_fv     (img_fv),
        .img_lv     (img_lv),
        .img_d      (img_d),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [APB_DW-1:0] got,
                             input logic [APB_DW-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ==================================================
    // APB master
    // ==================================================
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        if (pslverr !== exp_err) begin
            fail_run($sformatf("FAILED pslverr on write to 0x%h: got 0x%h, expected 0x%h",
                               addr, pslverr, exp_err));
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            fail_run("pready was low during an APB access phase");
        end
        if (pslverr !== exp_err) begin
            fail_run($sformatf("FAILED pslverr on read of 0x%h: got 0x%h, expected 0x%h",
                               addr, pslverr, exp_err));
        end
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ctrl(input int bank, input logic cap, input logic rd,
                              input logic exp_err);
        logic [APB_DW-1:0] data;
        data                          = '0;
        data[CTRL_CAP_BIT]            = cap;
        data[CTRL_RD_BIT]             = rd;
        data[CTRL_BANK_BIT +: BSEL_W] = BSEL_W'(bank);
        apb_write(REG_CTRL, data, exp_err);
    endtask

    task automatic set_header(input int bank, input logic [HDR_W-1:0] hdr);
        logic [APB_DW-1:0] rd;
        frame_hdr[bank] = hdr;
        apb_write(REG_HDR_LO, hdr[APB_DW-1:0], 1'b0);
        apb_write(REG_HDR_HI, hdr[HDR_W-1:APB_DW], 1'b0);
        apb_read(REG_HDR_HI, rd, 1'b0);
        check_reg("HDR_HI", rd, hdr[HDR_W-1:APB_DW]);
    endtask

    // Polls STATUS until the done bit is set and checks busy one bit below it
    task automatic wait_done(input int done_bit, input string what);
        logic [APB_DW-1:0] st;
        int                polls;
        polls = 0;
        apb_read(REG_STATUS, st, 1'b0);
        while (!st[done_bit]) begin
            polls++;
            if (polls > TIMEOUT) begin
                fail_run($sformatf("Timed out waiting for the %s to finish", what));
            end
            apb_read(REG_STATUS, st, 1'b0);
        end
        if (st[done_bit-1]) begin
            fail_run($sformatf("The %s reported done while still busy", what));
        end
    endtask

    // ==================================================
    // Frame model and pixel source
    // ==================================================
    task automatic fill_frame(input int bank, input int lines, input int width,
                              input int base, input int step);
        int i;
        frame_len[bank] = lines * width;
        for (i = 0; i < frame_len[bank]; i++) begin
            frame_pix[bank][i] = PIX_W'(base + i * step);
        end
    endtask

    function automatic int stored_len(input int bank);
        int n;
        n = HDR_WORDS + frame_len[bank];
        return (n > BANK_DEPTH) ? BANK_DEPTH : n;
    endfunction

    // Header word 0 is the top 16 bits and pixels are zero-extended
    function automatic logic [WORD_W-1:0] expected_word(input int bank, input int idx);
        logic [HDR_W-1:0] hdr;
        hdr = frame_hdr[bank];
        if (idx < HDR_WORDS) begin
            return WORD_W'(hdr >> ((HDR_WORDS - 1 - idx) * WORD_W));
        end
        return {{(WORD_W-PIX_W){1'b0}}, frame_pix[bank][idx-HDR_WORDS]};
    endfunction

    // Sampled where line and column, each modulo 4, are both zero
    task automatic count_tones(input int bank, input int width, output int hl, output int sh);
        logic [TONE_BITS-1:0] top;
        int                   i;
        hl = 0;
        sh = 0;
        for (i = 0; i < frame_len[bank]; i++) begin
            top = frame_pix[bank][i][PIX_W-1 -: TONE_BITS];
            if (((i / width) % 4 == 0) && ((i % width) % 4 == 0)) begin
                if (top == '1) begin
                    hl++;
                end else if (top == '0) begin
                    sh++;
                end
            end
        end
    endtask

    task automatic send_frame(input int bank, input int lines, input int width);
        int idx;
        int l;
        int c;
        idx = 0;
        @(posedge clk);
        img_fv <= 1'b0;
        img_lv <= 1'b0;
        img_d  <= '0;
        repeat (4) @(posedge clk);
        img_fv <= 1'b1;
        // Vertical blanking long enough for the header words
        repeat (8) @(posedge clk);
        for (l = 0; l < lines; l++) begin
            for (c = 0; c < width; c++) begin
                @(posedge clk);
                img_lv <= 1'b1;
                img_d  <= frame_pix[bank][idx];
                idx++;
            end
            @(posedge clk);
            img_lv <= 1'b0;
            img_d  <= '0;
            repeat (3) @(posedge clk);
        end
        img_fv <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic read_stream(input int bank, input logic random_ready);
        logic [APB_DW-1:0] rd;
        int                idx;
        int                cycles;
        int                rnd;
        int                total;
        total  = stored_len(bank);
        idx    = 0;
        cycles = 0;
        write_ctrl(bank, 1'b0, 1'b1, 1'b0);
        while (idx < total) begin
            if (random_ready) begin
                rnd = $random(seed);
            end else begin
                rnd = 1;
            end
            @(posedge clk);
            out_ready <= rnd[0];
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_word($sformatf("out_data[%0d]", idx), out_data, expected_word(bank, idx));
                idx++;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("Timed out after %0d of %0d stream words", idx, total));
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
        wait_done(3, "readout");
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            fail_run("out_valid stayed high after the stored length was sent");
        end
        apb_read(REG_WORD_COUNT, rd, 1'b0);
        check_count("WORD_COUNT", rd[CNT_W-1:0], CNT_W'(total));
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_after_reset();
        logic [APB_DW-1:0] rd;
        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("STATUS", rd, 32'h0);
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            fail_run($sformatf("FAILED out_valid: got 0x%h, expected 0x0", out_valid));
        end
        apb_read(5'h1C, rd, 1'b1);
    endtask

    task automatic test_capture_bank0();
        logic [APB_DW-1:0] rd;
        fill_frame(0, 3, 8, 12'h123, 37);
        set_header(0, 64'hA1B2_C3D4_E5F6_0718);
        // Frame already running, so capture has to wait for the next one
        @(posedge clk);
        img_fv <= 1'b1;
        img_lv <= 1'b1;
        img_d  <= 12'hFFF;
        write_ctrl(0, 1'b1, 1'b0, 1'b0);
        write_ctrl(1, 1'b1, 1'b0, 1'b1);
        // The refused write must leave bank 0 selected
        apb_read(REG_CTRL, rd, 1'b0);
        check_reg("CTRL", rd, 32'h0);
        send_frame(0, 3, 8);
        wait_done(1, "capture");
        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("STATUS", rd, 32'h02);
        read_stream(0, 1'b0);
        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("STATUS", rd, 32'h0A);
    endtask

    task automatic test_statistics();
        logic [APB_DW-1:0] rd;
        int                hl;
        int                sh;
        fill_frame(1, 6, 9, 12'h400, 1);
        // Sampled positions
        frame_pix[1][0]      = 12'hFFF;
        frame_pix[1][4]      = 12'hFE5;
        frame_pix[1][4*9+8]  = 12'hFF0;
        frame_pix[1][8]      = 12'h01F;
        frame_pix[1][4*9]    = 12'h000;
        // Decoys off the sampling grid
        frame_pix[1][9]      = 12'hFFF;
        frame_pix[1][1]      = 12'h000;
        frame_pix[1][2*9+4]  = 12'hFE0;
        frame_pix[1][5*9+8]  = 12'h010;
        set_header(1, 64'h5A5A_0F0F_1234_8765);
        write_ctrl(1, 1'b1, 1'b0, 1'b0);
        send_frame(1, 6, 9);
        wait_done(1, "capture");
        count_tones(1, 9, hl, sh);
        apb_read(REG_HIGHLIGHT, rd, 1'b0);
        check_reg("HIGHLIGHT", rd, APB_DW'(hl));
        apb_read(REG_SHADOW, rd, 1'b0);
        check_reg("SHADOW", rd, APB_DW'(sh));
        read_stream(1, 1'b0);
    endtask

    task automatic test_bank_independence();
        read_stream(0, 1'b0);
        read_stream(1, 1'b0);
    endtask

    task automatic test_back_pressure();
        read_stream(1, 1'b1);
        read_stream(0, 1'b1);
    endtask

    task automatic test_overflow();
        logic [APB_DW-1:0] rd;
        fill_frame(0, 5, 16, 12'h800, 53);
        set_header(0, 64'h0102_0304_0506_0708);
        write_ctrl(0, 1'b1, 1'b0, 1'b0);
        send_frame(0, 5, 16);
        wait_done(1, "capture");
        apb_read(REG_STATUS, rd, 1'b0);
        check_reg("STATUS", rd, 32'h1A);
        read_stream(0, 1'b1);
    endtask

    initial begin
        seed       = 32'h9e5b_2c54;
        fifoIn_rst = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        img_fv     = 1'b0;
        img_lv     = 1'b0;
        img_d      = '0;
        out_ready  = 1'b0;
        repeat (4) @(posedge clk);
        fifoIn_rst <= 1'b1;

        test_after_reset();
        test_capture_bank0();
        test_statistics();
        test_bank_independence();
        test_back_pressure();
        test_overflow();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/img_pkg.sv
rtl/img_apb_regs.sv
rtl/img_capture.sv
rtl/img_frame_bank.sv
rtl/img_readout.sv
rtl/img_ctrl_top.sv
testbench/tb_img_ctrl.sv
